// File: source/uart_pkg.sv
// UART echo shared definitions
// Line timing, FIFO sizing, vector types and FSM state encodings

package uart_pkg;

    // ======================================================================
    // Timing and sizing
    // ======================================================================
    localparam int CLK_HZ       = 1_000_000;         // System clock
    localparam int BAUD         = 62_500;            // Line rate
    localparam int BIT_CYCLES   = CLK_HZ / BAUD;     // Clocks per bit, 16
    localparam int HALF_BIT     = BIT_CYCLES / 2;    // Start bit centre offset
    localparam int TX_STOP_BITS = 2;                 // Echo side stop bits
    localparam int FIFO_DEPTH   = 4;                 // Entries
    localparam int FIFO_PTR_W   = 2;                 // log2 of FIFO_DEPTH

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [7:0]            byte_t;           // Data byte
    typedef logic [2:0]            bit_cnt_t;        // Data bit index
    typedef logic [15:0]           tick_cnt_t;       // Cycles within a bit
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;       // Read or write pointer
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;       // Fill level, 0 to DEPTH

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;                                    // Receiver FSM

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;                                    // Transmitter FSM

endpackage

// File: source/uart_receiver.sv
`timescale 1ns/1ps
// UART receiver, 8N1
// Synchronizes rx, detects the start bit and samples every bit at its centre
// A high stop bit pulses rx_valid, a low one pulses frame_error

module uart_receiver (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,
    output logic            rx_valid,
    output uart_pkg::byte_t rx_data,
    output logic            frame_error
);

    // ======================================================================
    // Line synchronizer
    // ======================================================================
    logic rx_meta;                                   // First sync stage
    logic rx_sync;                                   // Second sync stage
    logic rx_prev;                                   // Previous sync value
    logic rx_fall;                                   // High to low on the line

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                         // Line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Edge, not level, so a held low line after a bad stop bit does not re-arm
    assign rx_fall = rx_prev & ~rx_sync;

    // ======================================================================
    // Receive FSM
    // ======================================================================
    uart_pkg::rx_state_e state;                      // Frame position
    uart_pkg::tick_cnt_t tick;                       // Cycles into current bit
    uart_pkg::bit_cnt_t  bit_idx;                    // Data bit being sampled
    uart_pkg::byte_t     shift;                      // Assembled byte
    logic                bit_end;                    // Centre of next bit
    logic                start_mid;                  // Centre of start bit

    assign bit_end   = (tick == uart_pkg::tick_cnt_t'(uart_pkg::BIT_CYCLES - 1));
    assign start_mid = (tick == uart_pkg::tick_cnt_t'(uart_pkg::HALF_BIT - 1));
    assign rx_data   = shift;                        // Held until next frame

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= uart_pkg::RX_IDLE;
            tick        <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;                     // Pulses by default
            frame_error <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (rx_fall) begin
                        state <= uart_pkg::RX_START;
                        tick  <= uart_pkg::tick_cnt_t'(1); // Detect cost one cycle
                    end
                end
                uart_pkg::RX_START: begin
                    if (start_mid) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        if (!rx_sync) begin
                            state <= uart_pkg::RX_DATA;  // Real start bit
                        end else begin
                            state <= uart_pkg::RX_IDLE;  // Glitch, back off
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_pkg::bit_cnt_t'(7)) begin
                            state <= uart_pkg::RX_STOP;  // Last data bit taken
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        tick        <= '0;
                        rx_valid    <= rx_sync;      // Good stop bit
                        frame_error <= ~rx_sync;     // Byte dropped
                        state       <= uart_pkg::RX_IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // A frame ends either good or bad, and only from the stop bit
    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_valid || frame_error) |->
            !(rx_valid && frame_error) && $past(state == uart_pkg::RX_STOP));

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ps
// Show-ahead byte FIFO between receiver and transmitter
// Oldest byte sits on head while not_empty, a write when full is dropped
// and pulses overflow

module byte_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  uart_pkg::byte_t wr_data,
    input  logic            take,
    output uart_pkg::byte_t head,
    output logic            not_empty,
    output logic            overflow
);

    // ======================================================================
    // Storage and pointers
    // ======================================================================
    uart_pkg::byte_t     mem [uart_pkg::FIFO_DEPTH];  // Circular buffer
    uart_pkg::fifo_ptr_t wr_ptr;                      // Next free slot
    uart_pkg::fifo_ptr_t rd_ptr;                      // Oldest entry
    uart_pkg::fifo_cnt_t count;                       // Fill level
    logic                full;                        // No room left
    logic                do_write;                    // Accepted write

    assign full      = (count == uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_write  = wr_en & ~full;
    assign head      = mem[rd_ptr];                   // Show-ahead read

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en & full;                 // Byte lost
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;              // No empty recheck
            end
            case ({do_write, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;              // Both or neither
            endcase
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // Transmitter must only pop what is there
    a_take_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> not_empty);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH));

endmodule

// File: source/uart_transmitter.sv
`timescale 1ns/1ps
// UART transmitter, 8 data bits with two stop bits
// Pops the FIFO with a take pulse from IDLE and shifts the byte out LSB first

module uart_transmitter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            not_empty,
    input  uart_pkg::byte_t head,
    output logic            take,
    output logic            tx
);

    // ======================================================================
    // Transmit FSM
    // ======================================================================
    uart_pkg::tx_state_e state;                      // Frame position
    uart_pkg::tick_cnt_t tick;                       // Cycles into current bit
    uart_pkg::bit_cnt_t  bit_idx;                    // Data bit on the line
    uart_pkg::byte_t     shift;                      // Bits still to send
    logic                bit_end;                    // Last cycle of a bit
    logic                stop_end;                   // Last stop cycle in STOP

    assign bit_end  = (tick == uart_pkg::tick_cnt_t'(uart_pkg::BIT_CYCLES - 1));
    // One stop cycle is spent in IDLE so back-to-back frames are 11 bits
    assign stop_end = (tick == uart_pkg::tick_cnt_t'(
                          uart_pkg::TX_STOP_BITS * uart_pkg::BIT_CYCLES - 2));

    assign take = (state == uart_pkg::TX_IDLE) && not_empty;  // Pop and latch

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                         // Line idles high
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    tick <= '0;
                    if (take) begin
                        tx    <= 1'b0;               // Start bit
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        tx      <= shift[0];         // Bit 0
                        state   <= uart_pkg::TX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == uart_pkg::bit_cnt_t'(7)) begin
                            tx    <= 1'b1;           // First stop bit
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            tx <= shift[0];          // Next data bit
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (stop_end) begin
                        tick  <= '0;
                        state <= uart_pkg::TX_IDLE;  // Line stays high
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    // Payload register, loaded from head on take, drained LSB first
    always_ff @(posedge clk) begin
        if (take) begin
            shift <= head;
        end else if (bit_end && (state == uart_pkg::TX_START ||
                                 state == uart_pkg::TX_DATA)) begin
            shift <= shift >> 1;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    // A pop only from IDLE, and the start bit follows on the next cycle
    a_take_idle: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (state == uart_pkg::TX_IDLE) ##1 !tx);

endmodule

// File: source/uart_echo_top.sv
`timescale 1ns/1ps
// UART echo top level
// Receiver feeds a small FIFO, the transmitter sends each byte back on tx

module uart_echo_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx,
    output logic frame_error,
    output logic overflow
);

    // ======================================================================
    // Stage links
    // ======================================================================
    logic            rx_valid;                       // Receiver byte strobe
    uart_pkg::byte_t rx_data;                        // Received byte
    uart_pkg::byte_t head;                           // Oldest queued byte
    logic            not_empty;                      // FIFO holds data
    logic            take;                           // Transmitter pop

    // Serial in
    uart_receiver u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .frame_error (frame_error)
    );

    // Rate buffer, absorbs the extra stop bit on the way out
    byte_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (rx_valid),
        .wr_data   (rx_data),
        .take      (take),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    // Serial out
    uart_transmitter u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .not_empty (not_empty),
        .head      (head),
        .take      (take),
        .tx        (tx)
    );

endmodule

// File: verification/tb_uart_tasks.svh
// UART echo testbench helpers
// Serial line driver, serial line monitor and value checks

// ======================================================================
// Reporting
// ======================================================================
task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] actual,
                     input logic [31:0] expected);
    if (actual !== expected) begin
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        $display("Simulation failed");
        $fatal(1);
    end
endtask

function automatic uart_pkg::byte_t random_byte();
    return uart_pkg::byte_t'($random(seed));          // Fixed seed stream
endfunction

function automatic int tx_frame_cycles();
    return (9 + uart_pkg::TX_STOP_BITS) * uart_pkg::BIT_CYCLES;  // Start, data, stops
endfunction

// ======================================================================
// Serial driver
// ======================================================================
task automatic drive_rx(input logic level, input int cycles);
    @(posedge clk);
    rx <= level;
    repeat (cycles - 1) @(posedge clk);              // Hold the level
endtask

task automatic send_byte(input uart_pkg::byte_t data, input bit bad_stop = 1'b0);
    int i;
    send_starts.push_back(cycle_count);
    drive_rx(1'b0, uart_pkg::BIT_CYCLES);            // Start bit
    for (i = 0; i < 8; i++) begin
        drive_rx(data[i], uart_pkg::BIT_CYCLES);     // LSB first
    end
    drive_rx(~bad_stop, uart_pkg::BIT_CYCLES);       // Stop bit
    if (bad_stop) begin
        drive_rx(1'b1, uart_pkg::BIT_CYCLES);        // Back to idle
    end
endtask

// ======================================================================
// Serial monitor, samples tx on falling clock edges
// ======================================================================
task automatic wait_tx_start(input int max_cycles, output bit seen);
    logic prev;
    int   n;
    seen = 1'b0;
    n    = 0;
    @(negedge clk);
    prev = tx;
    while (!seen && n < max_cycles) begin
        @(negedge clk);
        n++;
        if (prev && !tx) begin
            seen = 1'b1;
            echo_starts.push_back(cycle_count);
        end
        prev = tx;
    end
endtask

task automatic sample_frame(output uart_pkg::byte_t data);
    int i;
    repeat (uart_pkg::BIT_CYCLES / 2) @(negedge clk);  // Start bit centre
    check("tx start bit", tx, 1'b0);
    for (i = 0; i < 8; i++) begin
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
        data[i] = tx;
    end
    for (i = 0; i < uart_pkg::TX_STOP_BITS; i++) begin
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
        check("tx stop bit", tx, 1'b1);
    end
endtask

task automatic recv_byte(output uart_pkg::byte_t data);
    bit seen;
    wait_tx_start(4 * tx_frame_cycles(), seen);
    if (!seen) begin
        report_failure("No start bit appeared on tx before the timeout");
    end
    sample_frame(data);
endtask

// File: verification/tb_uart_echo.sv
`timescale 1ns/1ps
// UART echo testbench
// Directed tests for idle, echo, burst order, frame error, glitch and overflow

module tb_uart_echo;

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;
    logic frame_error;
    logic overflow;

    int seed = 86560;                                // Random stimulus seed
    int cycle_count = 0;                             // Free running clock count
    int overflow_pulses = 0;
    int frame_error_pulses = 0;
    int send_starts[$];                              // Cycle of each rx frame start
    int echo_starts[$];                              // Cycle of each tx start bit

    `include "tb_uart_tasks.svh"

    uart_echo_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx          (rx),
        .tx          (tx),
        .frame_error (frame_error),
        .overflow    (overflow)
    );

    // ======================================================================
    // Clock and pulse counters
    // ======================================================================
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (overflow)    overflow_pulses    <= overflow_pulses + 1;
            if (frame_error) frame_error_pulses <= frame_error_pulses + 1;
        end
    end

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic echo_byte(input uart_pkg::byte_t data);
        uart_pkg::byte_t got;
        fork
            send_byte(data);
            recv_byte(got);
        join
        check("echoed byte", got, data);
    endtask

    task automatic idle_after_reset();
        bit seen;
        check("tx", tx, 1'b1);
        check("frame_error", frame_error, 1'b0);
        check("overflow", overflow, 1'b0);
        wait_tx_start(50, seen);                     // Line must stay quiet
        check("tx start while idle", seen, 1'b0);
    endtask

    task automatic single_echo();
        int fe0;
        int ov0;
        fe0 = frame_error_pulses;
        ov0 = overflow_pulses;
        echo_byte(random_byte());
        check("frame_error pulses", frame_error_pulses, fe0);
        check("overflow pulses", overflow_pulses, ov0);
    endtask

    task automatic burst_order();
        uart_pkg::byte_t sent [8];
        uart_pkg::byte_t got;
        int              ov0;
        int              i;
        int              j;
        int              k;
        int              lag_growth;
        ov0 = overflow_pulses;
        send_starts.delete();
        echo_starts.delete();
        for (i = 0; i < 8; i++) begin
            sent[i] = random_byte();
        end
        fork
            for (j = 0; j < 8; j++) begin
                send_byte(sent[j]);                  // Back to back
            end
            for (k = 0; k < 8; k++) begin
                recv_byte(got);
                check("burst byte", got, sent[k]);
            end
        join
        check("overflow pulses", overflow_pulses, ov0);
        lag_growth = (echo_starts[7] - send_starts[7]) - (echo_starts[0] - send_starts[0]);
        if (lag_growth >= tx_frame_cycles()) begin
            report_failure("Echo lag grew by a whole byte during the burst");
        end
    endtask

    task automatic frame_error_drop();
        int fe0;
        bit seen;
        fe0 = frame_error_pulses;
        fork
            send_byte(random_byte(), 1'b1);          // Low stop bit
            wait_tx_start(12 * tx_frame_cycles(), seen);  // Watch from the first bit
        join
        if (frame_error_pulses == fe0) begin
            report_failure("frame_error did not pulse after a low stop bit");
        end
        check("echo of a bad frame", seen, 1'b0);
        echo_byte(random_byte());
        check("frame_error pulses", frame_error_pulses, fe0 + 1);
    endtask

    task automatic glitch_reject();
        int fe0;
        bit seen;
        fe0 = frame_error_pulses;
        drive_rx(1'b0, uart_pkg::BIT_CYCLES / 4);    // Short of the start centre
        drive_rx(1'b1, uart_pkg::BIT_CYCLES);
        wait_tx_start(3 * tx_frame_cycles(), seen);
        check("echo after glitch", seen, 1'b0);
        check("frame_error pulses", frame_error_pulses, fe0);
        echo_byte(random_byte());
    endtask

    task automatic overflow_stream();
        uart_pkg::byte_t sent [60];
        uart_pkg::byte_t got [$];
        uart_pkg::byte_t b;
        int              ov0;
        int              i;
        int              pos;
        bit              seen;
        bit              done;
        ov0 = overflow_pulses;
        for (i = 0; i < 60; i++) begin
            sent[i] = random_byte();
        end
        done = 1'b0;
        fork
            foreach (sent[j]) begin
                send_byte(sent[j]);
            end
            while (!done && got.size() < 120) begin
                wait_tx_start(3 * tx_frame_cycles(), seen);  // Ends on long idle
                if (seen) begin
                    sample_frame(b);
                    got.push_back(b);
                end else begin
                    done = 1'b1;
                end
            end
        join
        if (overflow_pulses == ov0) begin
            report_failure("overflow never pulsed during the long stream");
        end
        check("echoes plus overflow pulses", got.size() + overflow_pulses - ov0, 60);
        if (got.size() < uart_pkg::FIFO_DEPTH + 1) begin
            report_failure("Too few bytes were echoed from the long stream");
        end
        for (i = 0; i < uart_pkg::FIFO_DEPTH + 1; i++) begin
            check("leading echoed byte", got[i], sent[i]);
        end
        check("last echoed byte", got[got.size() - 1], sent[59]);
        pos = 0;                                     // Greedy in-order match
        foreach (got[m]) begin
            while (pos < 60 && sent[pos] != got[m]) begin
                pos++;
            end
            if (pos == 60) begin
                report_failure("Echoed stream is not an in-order subsequence of the sent bytes");
            end
            pos++;                                   // Each sent byte used once
        end
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================
    initial begin
        rx    = 1'b1;                                // Line idles high
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        idle_after_reset();
        single_echo();
        burst_order();
        frame_error_drop();
        glitch_reject();
        overflow_stream();
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verification
source/uart_pkg.sv
source/uart_receiver.sv
source/byte_fifo.sv
source/uart_transmitter.sv
source/uart_echo_top.sv
verification/tb_uart_echo.sv

// File: Bender.yml
package:
  name: uart_echo

sources:
  - source/uart_pkg.sv
  - source/uart_receiver.sv
  - source/byte_fifo.sv
  - source/uart_transmitter.sv
  - source/uart_echo_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_uart_echo.sv
